// ==== stopwatch_top.f ====
design/clock_pkg.sv
design/stopwatch_pkg.sv
design/clock_generator.sv
design/key_debounce.sv
design/stopwatch_ctrl.sv
design/bcd_time_counter.sv
design/display_scan.sv
design/stopwatch_top.sv
bench/stopwatch_sva.sv
bench/tb_stopwatch.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the stopwatch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stopwatch -f stopwatch_top.f
out=$(./obj_dir/Vtb_stopwatch) || true
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// ==== bench/tb_stopwatch.sv ====
`timescale 1ns/1ps
module tb_stopwatch;

  localparam int DIV_COUNT_TB  = 2;
  localparam int DIV_SCAN_TB   = 3;
  localparam int DIV_BLINK_TB  = 40;
  localparam int CYC_PER_HUND  = 2 * DIV_COUNT_TB;  // One full count period
  localparam int RESET_CYCLES  = 10;
  localparam int SETTLE_CYCLES = 20;
  localparam int HOLD          = 40;     // Button held
  localparam int RELEASE       = 40;     // Button released after each press
  localparam int READ_LIMIT    = 200;    // Cycles to see all four digits
  localparam int WRAP_RUN      = 24200;  // Past 59.99
  localparam int NO_READ       = -1;
  localparam int SAME          = -2;     // Must match previous read
  localparam int ACT_START     = 0;
  localparam int ACT_RESET     = 1;
  localparam int ACT_GLITCH    = 2;
  localparam int ACT_WAIT      = 3;
  localparam int MODE_IDLE     = 0;
  localparam int MODE_RUN      = 1;
  localparam int MODE_PAUSE    = 2;
  // Active-low patterns for 0..9, bit 0 is segment a
  localparam logic [6:0] SEG_TABLE [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                            7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

  typedef struct {
    int act;
    int len;   // Hold or wait cycles
    int exp;   // Hundredths, or NO_READ / SAME
    int tol;
    int mode;  // Expected state after the row
  } row_t;

  logic       clk, rst_n, btn_start, btn_reset, led_run;
  logic [6:0] seg;
  logic [3:0] an;
  logic       led_q;            // led_run seen at the last falling edge
  row_t       rows[$];
  int unsigned lcg_state = 96;
  int         digit_val [4];    // Latest decoded value per anode
  int         upd_count [4];    // Times each digit was seen lit
  int         dark_total = 0;   // Cycles with every anode off
  int         mon_errors = 0;
  int         errors = 0;
  int         total_cycles = 0;
  int         limit_cycles = 0;

  stopwatch_top #(
    .DIV_COUNT(clock_pkg::div_count_t'(DIV_COUNT_TB)),
    .DIV_SCAN (clock_pkg::div_count_t'(DIV_SCAN_TB)),
    .DIV_BLINK(clock_pkg::div_count_t'(DIV_BLINK_TB))
  ) DUT (.clk, .rst_n, .btn_start, .btn_reset, .seg, .an, .led_run);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ****************************************
  // Helpers
  // ****************************************
  function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state >> 16);
  endfunction

  function automatic int seg_to_digit(input logic [6:0] s);
    for (int i = 0; i < 10; i++)
      if (SEG_TABLE[i] == s)
        return i;
    return -1;  // Not a digit
  endfunction

  // Distance on the 60.00 s dial
  function automatic int time_dist(input int a, input int b);
    int d;
    d = (a - b + 6000) % 6000;
    return (d > 3000) ? 6000 - d : d;
  endfunction

  task automatic add_row(input int act, input int len, input int exp, input int tol,
                         input int mode);
    rows.push_back(row_t'{act, len, exp, tol, mode});
    total_cycles += (act == ACT_WAIT) ? len : len + RELEASE;
    if (exp != NO_READ)
      total_cycles += READ_LIMIT;
  endtask

  task automatic build_table();
    int n1, n2, n3;
    n1 = 200 + 4 * (lcg_next() % 150);  // Multiples of 4 keep the count whole
    n2 = 200 + 4 * (lcg_next() % 150);
    n3 = 200 + 4 * (lcg_next() % 150);
    add_row(ACT_WAIT, 60, 0, 0, MODE_IDLE);            // Fresh reset shows 00.00
    add_row(ACT_GLITCH, 8, 0, 0, MODE_IDLE);
    add_row(ACT_START, HOLD, NO_READ, 0, MODE_RUN);
    add_row(ACT_WAIT, n1, NO_READ, 0, MODE_RUN);
    add_row(ACT_START, HOLD, (HOLD + RELEASE + n1) / CYC_PER_HUND, 2, MODE_PAUSE);
    add_row(ACT_WAIT, 200, SAME, 0, MODE_PAUSE);       // Frozen and blinking
    add_row(ACT_GLITCH, 8, SAME, 0, MODE_PAUSE);
    add_row(ACT_RESET, HOLD, 0, 0, MODE_IDLE);
    add_row(ACT_WAIT, 100, 0, 0, MODE_IDLE);
    add_row(ACT_START, HOLD, NO_READ, 0, MODE_RUN);
    add_row(ACT_WAIT, n2, NO_READ, 0, MODE_RUN);
    add_row(ACT_RESET, HOLD, NO_READ, 0, MODE_RUN);    // Ignored while running
    add_row(ACT_WAIT, n3, NO_READ, 0, MODE_RUN);
    add_row(ACT_START, HOLD, (2 * (HOLD + RELEASE) + n2 + n3) / CYC_PER_HUND, 2, MODE_PAUSE);
    add_row(ACT_RESET, HOLD, 0, 0, MODE_IDLE);
    add_row(ACT_START, HOLD, NO_READ, 0, MODE_RUN);
    add_row(ACT_WAIT, WRAP_RUN - HOLD - RELEASE, NO_READ, 0, MODE_RUN);
    add_row(ACT_START, HOLD, (WRAP_RUN / CYC_PER_HUND) % 6000, 2, MODE_PAUSE);
  endtask

  // Starts and ends on a rising edge
  task automatic press_key(input bit use_reset, input int hold);
    #1;
    if (use_reset)
      btn_reset = 1'b1;
    else
      btn_start = 1'b1;
    repeat (hold) @(posedge clk);
    #1;
    btn_start = 1'b0;
    btn_reset = 1'b0;
    repeat (RELEASE) @(posedge clk);
  endtask

  // Waits until every digit has been lit again
  task automatic read_display(output int value);
    int base [4];
    int waited;
    base = upd_count;
    waited = 0;
    while (waited < READ_LIMIT && !(upd_count[0] > base[0] && upd_count[1] > base[1]
           && upd_count[2] > base[2] && upd_count[3] > base[3]))
    begin
      @(posedge clk);
      waited++;
    end
    if (waited >= READ_LIMIT)
    begin
      errors++;
      $display("Display did not light all four digits within %0d cycles", READ_LIMIT);
    end
    value = digit_val[3] * 1000 + digit_val[2] * 100 + digit_val[1] * 10 + digit_val[0];
  endtask

  // ****************************************
  // Display monitor
  // ****************************************
  always @(negedge clk)
  begin
    int d;
    if (rst_n)
    begin
      led_q = led_run;
      if (an == 4'hf)
        dark_total++;  // Blanked
      else if ($countones(~an) == 1)
        for (int i = 0; i < 4; i++)
          if (!an[i])
          begin
            d = seg_to_digit(seg);
            if (d < 0)
            begin
              mon_errors++;
              $display("Fail seg 0x%h on digit %0d is not a digit code", seg, i);
            end
            else
            begin
              digit_val[i] = d;
              upd_count[i]++;
            end
          end
    end
  end

  // ****************************************
  // Stimulus table and checks
  // ****************************************
  initial
  begin
    row_t r;
    int got;
    int want;
    int last_read;
    int dark_before;
    rst_n = 1'b0;
    btn_start = 1'b0;
    btn_reset = 1'b0;
    last_read = 0;
    build_table();
    limit_cycles = (RESET_CYCLES + SETTLE_CYCLES + total_cycles) * 3 / 2;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (SETTLE_CYCLES) @(posedge clk);
    foreach (rows[i])
    begin
      r = rows[i];
      dark_before = dark_total;
      if (r.act == ACT_WAIT)
        repeat (r.len) @(posedge clk);
      else
        press_key(r.act == ACT_RESET, r.len);  // Glitch is a short start press
      if (led_q !== (r.mode == MODE_RUN))
      begin
        errors++;
        $display("Fail led_run got 0x%h expected 0x%h in row %0d", led_q,
                 r.mode == MODE_RUN, i);
      end
      if (r.act == ACT_WAIT && r.mode != MODE_PAUSE && dark_total != dark_before)
      begin
        errors++;
        $display("Display went dark outside pause in row %0d", i);
      end
      if (r.act == ACT_WAIT && r.mode == MODE_PAUSE && r.len >= 2 * DIV_BLINK_TB
          && dark_total == dark_before)
      begin
        errors++;
        $display("Display never blinked during pause in row %0d", i);
      end
      if (r.exp != NO_READ)
      begin
        read_display(got);
        want = (r.exp == SAME) ? last_read : r.exp;
        if (time_dist(got, want) > r.tol)
        begin
          errors++;
          $display("Fail display_time got 0x%0h expected 0x%0h in row %0d", got, want, i);
        end
        last_read = got;
      end
    end
    $display("Errors: %0d", errors + mon_errors);
    if (errors + mon_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog, limit follows the table
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== bench/stopwatch_sva.sv ====
`timescale 1ns/1ps
module stopwatch_sva import stopwatch_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input seg_t   seg,
  input anode_t an,
  input logic   led_run,
  input logic   blank
);

  // ****************************************
  // Display scan
  // ****************************************
  a_single_anode: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(~an) <= 1)  // One digit at a time
    else $error("More than one anode low, an %h", an);

  a_dark_no_seg: assert property (@(posedge clk) disable iff (!rst_n)
    (an == 4'hf) |-> (seg == SEG_BLANK))
    else $error("Segments driven with no anode lit, seg %h", seg);

  // Control, never blinking while running
  a_run_not_blank: assert property (@(posedge clk) disable iff (!rst_n)
    !(led_run && blank))
    else $error("led_run and blank high together");

endmodule

bind stopwatch_top stopwatch_sva u_sva (
  .clk(clk), .rst_n(rst_n), .seg(seg), .an(an), .led_run(led_run), .blank(blank)
);

// ==== design/stopwatch_top.sv ====
`timescale 1ns/1ps
module stopwatch_top import clock_pkg::*, stopwatch_pkg::*; #(
  parameter div_count_t DIV_COUNT = DEF_DIV_COUNT,
  parameter div_count_t DIV_SCAN  = DEF_DIV_SCAN,
  parameter div_count_t DIV_BLINK = DEF_DIV_BLINK
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   btn_start,  // Raw level
  input  logic   btn_reset,  // Raw level
  output seg_t   seg,
  output anode_t an,
  output logic   led_run
);

  logic clk_count, clk_scan, clk_blink;  // Slow square waves, sampled in clk domain
  logic start_pulse, reset_pulse;
  logic count_en, clear, blank;
  bcd_t hund_ones, hund_tens, sec_ones, sec_tens;

  // ****************************************
  // Timebase and keys
  // ****************************************
  clock_generator #(
    .DIV_COUNT(DIV_COUNT),
    .DIV_SCAN (DIV_SCAN),
    .DIV_BLINK(DIV_BLINK)
  ) u_clock_generator (.clk, .rst_n, .clk_count, .clk_scan, .clk_blink);

  key_debounce u_key_start (.clk, .rst_n, .clk_scan, .btn(btn_start), .press(start_pulse));
  key_debounce u_key_reset (.clk, .rst_n, .clk_scan, .btn(btn_reset), .press(reset_pulse));

  // ****************************************
  // Control, time and display
  // ****************************************
  stopwatch_ctrl u_ctrl (
    .clk, .rst_n, .start_pulse, .reset_pulse, .clk_blink,
    .count_en, .clear, .blank, .led_run
  );

  bcd_time_counter u_counter (
    .clk, .rst_n, .clk_count, .count_en, .clear,
    .hund_ones, .hund_tens, .sec_ones, .sec_tens
  );

  display_scan u_scan (
    .clk, .rst_n, .clk_scan, .blank,
    .hund_ones, .hund_tens, .sec_ones, .sec_tens, .seg, .an
  );

endmodule

// ==== design/display_scan.sv ====
`timescale 1ns/1ps
module display_scan import stopwatch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clk_scan,
  input  logic   blank,      // Whole display dark
  input  bcd_t   hund_ones,
  input  bcd_t   hund_tens,
  input  bcd_t   sec_ones,
  input  bcd_t   sec_tens,
  output seg_t   seg,
  output anode_t an
);

  logic       scan_q;
  logic       scan_rise;
  digit_idx_t idx, idx_next;
  bcd_t       digit;     // Selected for the next slot
  seg_t       seg_dec;

  assign scan_rise = clk_scan & ~scan_q;
  assign idx_next  = idx - 2'd1;  // 3, 2, 1, 0, 3 ...

  always_comb
  begin
    unique case (idx_next)
      2'd3:    digit = sec_tens;
      2'd2:    digit = sec_ones;
      2'd1:    digit = hund_tens;
      default: digit = hund_ones;
    endcase
    // BCD to segments, bit 0 is a
    case (digit)
      4'd0:    seg_dec = 7'b100_0000;
      4'd1:    seg_dec = 7'b111_1001;
      4'd2:    seg_dec = 7'b010_0100;
      4'd3:    seg_dec = 7'b011_0000;
      4'd4:    seg_dec = 7'b001_1001;
      4'd5:    seg_dec = 7'b001_0010;
      4'd6:    seg_dec = 7'b000_0010;
      4'd7:    seg_dec = 7'b111_1000;
      4'd8:    seg_dec = 7'b000_0000;
      4'd9:    seg_dec = 7'b001_0000;
      default: seg_dec = SEG_BLANK;  // Not a BCD code
    endcase
  end

  // Index, anodes and segments move together
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      scan_q <= 1'b0;
      idx    <= '0;
      an     <= '1;  // Nothing lit
      seg    <= SEG_BLANK;
    end
    else
    begin
      scan_q <= clk_scan;
      if (scan_rise)
      begin
        idx <= idx_next;
        an  <= blank ? '1 : ~(anode_t'(1) << idx_next);
        seg <= blank ? SEG_BLANK : seg_dec;
      end
    end
  end

endmodule

// ==== design/bcd_time_counter.sv ====
`timescale 1ns/1ps
module bcd_time_counter import stopwatch_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic clk_count,
  input  logic count_en,
  input  logic clear,
  output bcd_t hund_ones,
  output bcd_t hund_tens,
  output bcd_t sec_ones,
  output bcd_t sec_tens
);

  logic count_q;    // Last seen count clock
  logic step;       // Add one hundredth this cycle
  bcd_t h1_next, h10_next, s1_next, s10_next;

  assign step = clk_count & ~count_q & count_en;

  // ****************************************
  // Carry ripple, limits 9 9 9 5
  // ****************************************
  always_comb
  begin
    h1_next  = hund_ones + 4'd1;
    h10_next = hund_tens;
    s1_next  = sec_ones;
    s10_next = sec_tens;
    if (hund_ones == 4'd9)
    begin
      h1_next  = 4'd0;
      h10_next = (hund_tens == 4'd9) ? 4'd0 : hund_tens + 4'd1;
      if (hund_tens == 4'd9)
      begin
        s1_next = (sec_ones == 4'd9) ? 4'd0 : sec_ones + 4'd1;
        if (sec_ones == 4'd9)
          s10_next = (sec_tens == 4'd5) ? 4'd0 : sec_tens + 4'd1;  // Wrap after 59.99
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_q   <= 1'b0;
      hund_ones <= '0;
      hund_tens <= '0;
      sec_ones  <= '0;
      sec_tens  <= '0;
    end
    else
    begin
      count_q <= clk_count;
      if (clear)
      begin
        hund_ones <= '0;  // Clear beats a pending step
        hund_tens <= '0;
        sec_ones  <= '0;
        sec_tens  <= '0;
      end
      else if (step)
      begin
        hund_ones <= h1_next;
        hund_tens <= h10_next;
        sec_ones  <= s1_next;
        sec_tens  <= s10_next;
      end
    end
  end

endmodule

// ==== design/stopwatch_ctrl.sv ====
`timescale 1ns/1ps
module stopwatch_ctrl import stopwatch_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start_pulse,
  input  logic reset_pulse,
  input  logic clk_blink,
  output logic count_en,  // High only while running
  output logic clear,     // One-cycle zero request
  output logic blank,     // Blink mask for the display
  output logic led_run
);

  sw_state_t state, state_next;

  // ****************************************
  // Transitions
  // ****************************************
  always_comb
  begin
    state_next = state;
    unique case (state)
      st_idle:
        if (start_pulse)
          state_next = st_run;
      st_run:
        if (start_pulse)
          state_next = st_pause;  // Reset ignored here
      st_pause:
        if (reset_pulse)
          state_next = st_idle;   // Reset wins over start
        else if (start_pulse)
          state_next = st_run;
      default:
        state_next = st_idle;
    endcase
  end

  // State and registered outputs
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      count_en <= 1'b0;
      clear    <= 1'b0;
      blank    <= 1'b0;
      led_run  <= 1'b0;
    end
    else
    begin
      state    <= state_next;
      count_en <= (state_next == st_run);
      led_run  <= (state_next == st_run);
      clear    <= (state == st_pause) && reset_pulse;
      blank    <= (state_next == st_pause) && clk_blink;  // Flash while paused
    end
  end

endmodule

// ==== design/key_debounce.sv ====
`timescale 1ns/1ps
module key_debounce (
  input  logic clk,
  input  logic rst_n,
  input  logic clk_scan,  // Sampling strobe source
  input  logic btn,       // Raw button level
  output logic press      // One-cycle pulse per accepted press
);

  logic       btn_meta, btn_sync;  // Two-flop synchronizer
  logic       scan_q;              // Last seen scan clock
  logic       scan_rise;
  logic [3:0] hist;                // Newest sample in bit 0
  logic       accepted;            // Debounced level

  assign scan_rise = clk_scan & ~scan_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      btn_meta <= 1'b0;
      btn_sync <= 1'b0;
      scan_q   <= 1'b0;
      hist     <= '0;
      accepted <= 1'b0;
      press    <= 1'b0;
    end
    else
    begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
      scan_q   <= clk_scan;
      if (scan_rise)
        hist <= {hist[2:0], btn_sync};  // Sample on scan edge
      // Level moves only when four samples agree
      if (&hist)
        accepted <= 1'b1;
      else if (~|hist)
        accepted <= 1'b0;
      press <= (&hist) & ~accepted;  // Rising accepted level
    end
  end

endmodule

// ==== design/clock_generator.sv ====
`timescale 1ns/1ps
module clock_generator import clock_pkg::*; #(
  parameter div_count_t DIV_COUNT = DEF_DIV_COUNT,
  parameter div_count_t DIV_SCAN  = DEF_DIV_SCAN,
  parameter div_count_t DIV_BLINK = DEF_DIV_BLINK
) (
  input  logic clk,
  input  logic rst_n,
  output logic clk_count,  // Hundredths step
  output logic clk_scan,   // Digit mux and key sampling
  output logic clk_blink   // Pause flash
);

  div_count_t cnt_count, cnt_count_next;
  div_count_t cnt_scan, cnt_scan_next;
  div_count_t cnt_blink, cnt_blink_next;
  logic clk_count_next, clk_scan_next, clk_blink_next;

  // ****************************************
  // Next-state logic, one section per output
  // ****************************************
  always_comb
  begin
    // Count clock
    cnt_count_next = (cnt_count == DIV_COUNT - 1'b1) ? '0 : cnt_count + 1'b1;
    clk_count_next = (cnt_count == DIV_COUNT - 1'b1) ? ~clk_count : clk_count;
    // Scan clock
    cnt_scan_next = (cnt_scan == DIV_SCAN - 1'b1) ? '0 : cnt_scan + 1'b1;
    clk_scan_next = (cnt_scan == DIV_SCAN - 1'b1) ? ~clk_scan : clk_scan;
    // Blink clock
    cnt_blink_next = (cnt_blink == DIV_BLINK - 1'b1) ? '0 : cnt_blink + 1'b1;
    clk_blink_next = (cnt_blink == DIV_BLINK - 1'b1) ? ~clk_blink : clk_blink;
  end

  // ****************************************
  // Counter and output flops
  // ****************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_count <= '0;
      cnt_scan  <= '0;
      cnt_blink <= '0;
      clk_count <= 1'b0;  // All outputs start low
      clk_scan  <= 1'b0;
      clk_blink <= 1'b0;
    end
    else
    begin
      cnt_count <= cnt_count_next;
      cnt_scan  <= cnt_scan_next;
      cnt_blink <= cnt_blink_next;
      clk_count <= clk_count_next;
      clk_scan  <= clk_scan_next;
      clk_blink <= clk_blink_next;
    end
  end

endmodule

// ==== design/stopwatch_pkg.sv ====
package stopwatch_pkg;

  // One decimal digit
  typedef logic [3:0] bcd_t;

  // Segments, active low
  // Bit 0 is a, bit 6 is g
  typedef logic [6:0] seg_t;

  // One-hot digit enable, active low
  typedef logic [3:0] anode_t;

  // Scanned digit index
  // 3 = seconds tens ... 0 = hundredths ones
  typedef logic [1:0] digit_idx_t;

  // ****************************************
  // Control FSM
  // ****************************************
  typedef enum logic [1:0] {
    st_idle,   // Cleared, waiting for start
    st_run,    // Counting
    st_pause   // Frozen, display blinks
  } sw_state_t;

  // All segments dark
  localparam seg_t SEG_BLANK = 7'b111_1111;

endpackage

// ==== design/clock_pkg.sv ====
package clock_pkg;

  // Divider counter, wide enough for the slowest half-period
  typedef logic [24:0] div_count_t;

  // ****************************************
  // Default half-periods, 40 MHz board clock
  // ****************************************
  // 100 Hz count clock, one step per hundredth
  localparam div_count_t DEF_DIV_COUNT = div_count_t'(200000);

  // 1 kHz scan clock for digit mux and keys
  localparam div_count_t DEF_DIV_SCAN = div_count_t'(20000);

  // 1 Hz blink clock for the paused display
  localparam div_count_t DEF_DIV_BLINK = div_count_t'(20000000);

  // Full period is twice the half-period
  // Counters run 0 .. DIV-1, then wrap and toggle

endpackage
